// File: include/lb_settings.svh
`ifndef LB_SETTINGS_SVH
`define LB_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////////////
// Datapath sizing
//////////////////////////////////////////////////////////////////////////////

`define LB_PIX_W    16   // Bits per pixel.
`define LB_MAX_LEN  128  // Words per bank.
`define LB_ADDR_W   7    // Bank word address.

//////////////////////////////////////////////////////////////////////////////
// APB register map, byte offsets
//////////////////////////////////////////////////////////////////////////////

`define LB_REG_LEN     4'h0  // Line length, RW.
`define LB_REG_CTRL    4'h4  // Bit 0 enables readout.
`define LB_REG_COUNT   4'h8  // Finished lines, RO.
`define LB_REG_STATUS  4'hC  // State and pending count, RO.

`endif

// File: hw/lb_pkg.sv
`include "lb_settings.svh"

package lb_pkg;

  // One pixel as carried through the buffer.
  typedef logic [`LB_PIX_W-1:0] pix_t;

  // Word address inside one bank.
  typedef logic [`LB_ADDR_W-1:0] addr_t;

  // One bit wider than the address so a full bank length fits.
  typedef logic [`LB_ADDR_W:0] len_t;

  // Readout controller states.
  typedef enum logic [2:0] {
    IDLE       = 3'd0,  // Waiting for a full line.
    START      = 3'd1,  // Waiting for downstream.
    FIRST_READ = 3'd2,  // Prime the memory read.
    READ1      = 3'd3,  // First word on the output.
    READ2      = 3'd4,  // Remaining words.
    DONE       = 3'd5   // Finish strobe, free the bank.
  } lb_state_e;

endpackage

// File: hw/lb_apb_regs.sv
`include "lb_settings.svh"

module lb_apb_regs (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               i_psel,
  input  logic               i_penable,
  input  logic               i_pwrite,
  input  logic [3:0]         i_paddr,
  input  logic [31:0]        i_pwdata,
  output logic [31:0]        o_prdata,
  output logic               o_pready,
  output logic               o_pslverr,
  input  lb_pkg::lb_state_e  i_state,
  input  logic [1:0]         i_pending,
  input  logic               i_line_finished,
  output lb_pkg::len_t       o_line_len,
  output logic               o_enable
);

  import lb_pkg::*;

  logic        access;
  logic        wr_fire;
  logic        mapped;
  logic [31:0] line_count;

  assign access  = i_psel & i_penable;
  assign wr_fire = access & i_pwrite & mapped;

  ////////////////////////////////////////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    mapped   = 1'b1;
    o_prdata = '0;
    case (i_paddr)
      `LB_REG_LEN:    o_prdata = {24'd0, o_line_len};
      `LB_REG_CTRL:   o_prdata = {31'd0, o_enable};
      `LB_REG_COUNT:  o_prdata = line_count;
      `LB_REG_STATUS: o_prdata = {26'd0, i_pending, 1'b0, i_state};
      default:        mapped   = 1'b0;
    endcase
  end

  assign o_pready  = 1'b1;              // No wait states.
  assign o_pslverr = access & ~mapped;

  ////////////////////////////////////////////////////////////////////////////
  // Writable registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_line_len <= len_t'(`LB_MAX_LEN);
      o_enable   <= 1'b0;
    end else if (wr_fire) begin
      if (i_paddr == `LB_REG_LEN) o_line_len <= i_pwdata[`LB_ADDR_W:0];
      if (i_paddr == `LB_REG_CTRL) o_enable <= i_pwdata[0];
    end
  end

  // One count per line drained.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      line_count <= '0;
    end else if (i_line_finished) begin
      line_count <= line_count + 32'd1;
    end
  end

endmodule

// File: hw/lb_write_port.sv
module lb_write_port (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          i_pix_valid,
  input  lb_pkg::pix_t  i_pix_data,
  output logic          o_pix_ready,
  input  lb_pkg::len_t  i_line_len,
  input  logic          i_release,
  output logic          o_line_ready,
  output logic [1:0]    o_pending,
  output logic          o_wr_en,
  output logic          o_wr_bank,
  output lb_pkg::addr_t o_wr_addr,
  output lb_pkg::pix_t  o_wr_data
);

  import lb_pkg::*;

  logic accept;
  logic line_done;

  assign o_pix_ready = (o_pending != 2'd2);  // Both banks full.
  assign accept      = i_pix_valid & o_pix_ready;
  assign line_done   = accept & (len_t'(o_wr_addr) == i_line_len - len_t'(1));

  assign o_wr_en      = accept;
  assign o_wr_data    = i_pix_data;
  assign o_line_ready = (o_pending != 2'd0);

  // Address and bank.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_wr_addr <= '0;
      o_wr_bank <= 1'b0;
    end else if (line_done) begin
      o_wr_addr <= '0;
      o_wr_bank <= ~o_wr_bank;
    end else if (accept) begin
      o_wr_addr <= o_wr_addr + addr_t'(1);
    end
  end

  // Lines written but not yet drained.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_pending <= 2'd0;
    end else begin
      case ({line_done, i_release})
        2'b10:   o_pending <= o_pending + 2'd1;
        2'b01:   o_pending <= o_pending - 2'd1;
        default: o_pending <= o_pending;  // Both or neither.
      endcase
    end
  end

endmodule

// File: hw/lb_line_ram.sv
`include "lb_settings.svh"

module lb_line_ram (
  input  logic          clk,
  input  logic          i_wr_en,
  input  logic          i_wr_bank,
  input  lb_pkg::addr_t i_wr_addr,
  input  lb_pkg::pix_t  i_wr_data,
  input  logic          i_rd_en,
  input  logic          i_rd_bank,
  input  lb_pkg::addr_t i_rd_addr,
  output lb_pkg::pix_t  o_rd_data
);

  import lb_pkg::*;

  // Bank bit on top of the word address.
  pix_t mem [0:2*`LB_MAX_LEN-1];

  always_ff @(posedge clk) begin
    if (i_wr_en) begin
      mem[{i_wr_bank, i_wr_addr}] <= i_wr_data;
    end
  end

  // Data follows the address by one cycle.
  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      o_rd_data <= mem[{i_rd_bank, i_rd_addr}];
    end
  end

endmodule

// File: hw/lb_read_port.sv
module lb_read_port (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          i_rd_en,
  input  logic          i_release,
  input  lb_pkg::len_t  i_line_len,
  output logic          o_rd_bank,
  output lb_pkg::addr_t o_rd_addr,
  output logic          o_last_done
);

  import lb_pkg::*;

  len_t delivered;  // Words already on the output.

  // The word now on the output is the last one.
  assign o_last_done = (delivered == i_line_len - len_t'(1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rd_addr <= '0;
    end else if (i_release) begin
      o_rd_addr <= '0;
    end else if (i_rd_en) begin
      o_rd_addr <= o_rd_addr + addr_t'(1);
    end
  end

  // The read of address zero only primes the memory, so it is not a
  // delivered word. At full length the final lookahead wraps to zero, but
  // by then last_done is already up.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delivered <= '0;
    end else if (i_release) begin
      delivered <= '0;
    end else if (i_rd_en && (o_rd_addr != '0)) begin
      delivered <= delivered + len_t'(1);
    end
  end

  // Drain the banks in the order they were filled.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      o_rd_bank <= 1'b0;
    end else if (i_release) begin
      o_rd_bank <= ~o_rd_bank;
    end
  end

endmodule

// File: hw/line_buffer_controller.sv
module line_buffer_controller (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              i_enable,
  input  logic              i_line_ready,
  input  logic              i_out_ready,
  input  logic              i_last_done,
  output logic              o_rd_en,
  output logic              o_release,
  output logic              o_valid,
  output logic              o_start,
  output logic              o_finish,
  output lb_pkg::lb_state_e o_state
);

  import lb_pkg::*;

  lb_state_e state;
  lb_state_e next_state;

  assign o_state = state;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    next_state = state;
    case (state)
      IDLE:       if (i_enable && i_line_ready) next_state = START;
      START:      if (i_out_ready) next_state = FIRST_READ;  // Line-level handshake.
      FIRST_READ: next_state = READ1;
      READ1:      next_state = READ2;
      READ2:      if (i_last_done) next_state = DONE;
      DONE:       next_state = IDLE;
      default:    next_state = IDLE;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Strobe decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    o_rd_en   = 1'b0;
    o_valid   = 1'b0;
    o_start   = 1'b0;
    o_release = 1'b0;
    o_finish  = 1'b0;
    case (state)
      FIRST_READ: begin
        o_rd_en = 1'b1;  // Address zero, no data yet.
      end
      READ1: begin
        o_rd_en = 1'b1;
        o_valid = 1'b1;
        o_start = 1'b1;
      end
      READ2: begin
        o_rd_en = 1'b1;
        o_valid = 1'b1;
      end
      DONE: begin
        o_release = 1'b1;
        o_finish  = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

// File: hw/line_buffer_top.sv
module line_buffer_top (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_psel,
  input  logic         i_penable,
  input  logic         i_pwrite,
  input  logic [3:0]   i_paddr,
  input  logic [31:0]  i_pwdata,
  output logic [31:0]  o_prdata,
  output logic         o_pready,
  output logic         o_pslverr,
  input  logic         i_pix_valid,
  input  lb_pkg::pix_t i_pix_data,
  output logic         o_pix_ready,
  output logic         o_valid,
  output lb_pkg::pix_t o_data,
  output logic         o_start,
  output logic         o_finish,
  input  logic         i_out_ready
);

  import lb_pkg::*;

  lb_state_e state;
  len_t      line_len;
  logic      enable;
  logic      line_ready;
  logic      last_done;
  logic      rd_en;
  logic      release_line;
  logic [1:0] pending;

  logic  wr_en;
  logic  wr_bank;
  addr_t wr_addr;
  pix_t  wr_data;
  logic  rd_bank;
  addr_t rd_addr;

  lb_apb_regs lb_apb_regs_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_psel          (i_psel),
    .i_penable       (i_penable),
    .i_pwrite        (i_pwrite),
    .i_paddr         (i_paddr),
    .i_pwdata        (i_pwdata),
    .o_prdata        (o_prdata),
    .o_pready        (o_pready),
    .o_pslverr       (o_pslverr),
    .i_state         (state),
    .i_pending       (pending),
    .i_line_finished (release_line),
    .o_line_len      (line_len),
    .o_enable        (enable)
  );

  lb_write_port lb_write_port_inst (
    .clk (clk), .rst_n (rst_n),
    .i_pix_valid (i_pix_valid), .i_pix_data (i_pix_data), .o_pix_ready (o_pix_ready),
    .i_line_len (line_len), .i_release (release_line),
    .o_line_ready (line_ready), .o_pending (pending),
    .o_wr_en (wr_en), .o_wr_bank (wr_bank), .o_wr_addr (wr_addr), .o_wr_data (wr_data)
  );

  lb_line_ram lb_line_ram_inst (
    .clk (clk),
    .i_wr_en (wr_en), .i_wr_bank (wr_bank), .i_wr_addr (wr_addr), .i_wr_data (wr_data),
    .i_rd_en (rd_en), .i_rd_bank (rd_bank), .i_rd_addr (rd_addr), .o_rd_data (o_data)
  );

  lb_read_port lb_read_port_inst (
    .clk (clk), .rst_n (rst_n),
    .i_rd_en (rd_en), .i_release (release_line), .i_line_len (line_len),
    .o_rd_bank (rd_bank), .o_rd_addr (rd_addr), .o_last_done (last_done)
  );

  line_buffer_controller line_buffer_controller_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_enable     (enable),
    .i_line_ready (line_ready),
    .i_out_ready  (i_out_ready),
    .i_last_done  (last_done),
    .o_rd_en      (rd_en),
    .o_release    (release_line),
    .o_valid      (o_valid),
    .o_start      (o_start),
    .o_finish     (o_finish),
    .o_state      (state)
  );

endmodule

// File: bench/tb_line_buffer.sv
`include "lb_settings.svh"

module tb_line_buffer;

  import lb_pkg::*;

  localparam int PERIOD    = 20;
  localparam int NUM_TESTS = 6;

  ////////////////////////////////////////////////////////////////////////////
  // Test table, one row per test
  ////////////////////////////////////////////////////////////////////////////

  int row_len    [NUM_TESTS] = '{16, 16, 16, 2, 128, 8};
  int row_lines  [NUM_TESTS] = '{1, 4, 2, 3, 2, 2};
  int row_ready  [NUM_TESTS] = '{0, 0, 60, 0, 0, 0};  // Cycle downstream turns ready.
  bit row_enable [NUM_TESTS] = '{1, 1, 1, 1, 1, 0};
  bit row_hold   [NUM_TESTS] = '{0, 0, 1, 0, 0, 1};   // Output still held at source end.

  logic        clk;
  logic        rst_n;
  logic        i_psel;
  logic        i_penable;
  logic        i_pwrite;
  logic [3:0]  i_paddr;
  logic [31:0] i_pwdata;
  logic [31:0] o_prdata;
  logic        o_pready;
  logic        o_pslverr;
  logic        i_pix_valid;
  pix_t        i_pix_data;
  logic        o_pix_ready;
  logic        o_valid;
  pix_t        o_data;
  logic        o_start;
  logic        o_finish;
  logic        i_out_ready;

  pix_t expected_q [$];
  pix_t exp_px;
  int   errors;
  int   cur_len;
  int   word_idx;
  int   test_words;
  int   test_lines;
  int   total_lines;
  int   tests_failed;

  line_buffer_top line_buffer_top_inst (
    .clk (clk), .rst_n (rst_n),
    .i_psel (i_psel), .i_penable (i_penable), .i_pwrite (i_pwrite),
    .i_paddr (i_paddr), .i_pwdata (i_pwdata), .o_prdata (o_prdata),
    .o_pready (o_pready), .o_pslverr (o_pslverr),
    .i_pix_valid (i_pix_valid), .i_pix_data (i_pix_data), .o_pix_ready (o_pix_ready),
    .o_valid (o_valid), .o_data (o_data), .o_start (o_start), .o_finish (o_finish),
    .i_out_ready (i_out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Budget grows with the words in the table.
  initial begin
    int budget;
    budget = 0;
    for (int r = 0; r < NUM_TESTS; r++) budget += row_lines[r] * row_len[r] + 10;
    budget = 40 + 2 * budget;
    #(budget * PERIOD);
    $display("Timeout: the run did not complete within %0d cycles", budget);
    $display("Simulation FAILED");
    $finish;
  end

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic report_failure(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    errors++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB driver
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    @(negedge clk);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = wr;
    i_paddr   = addr;
    i_pwdata  = wdata;
    @(negedge clk);
    i_penable = 1'b1;
    @(posedge clk);  // End of access phase.
    rdata = o_prdata;
    err   = o_pslverr;
    assert (o_pready === 1'b1) else report_failure("APB slave inserted a wait state");
    @(negedge clk);
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    logic        err;
    apb_access(1'b1, addr, wdata, unused, err);
    assert (err === 1'b0) else report_mismatch($sformatf("pslverr on write to 0x%h", addr));
  endtask

  // One pixel per cycle, stalls while o_pix_ready is low.
  task automatic send_pixels(input int count);
    pix_t px;
    for (int i = 0; i < count; i++) begin
      px = pix_t'($urandom);
      @(negedge clk);
      i_pix_valid = 1'b1;
      i_pix_data  = px;
      @(posedge clk);
      while (!o_pix_ready) @(posedge clk);
      expected_q.push_back(px);
    end
    @(negedge clk);
    i_pix_valid = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (o_valid) begin
        if (expected_q.size() == 0) begin
          report_failure("output word appeared with no pixel written for it");
        end else begin
          exp_px = expected_q.pop_front();
          assert (o_data === exp_px)
            else report_mismatch($sformatf("word %0d got %h expected %h",
                                           word_idx, o_data, exp_px));
        end
        assert (o_start === (word_idx == 0))
          else report_mismatch($sformatf("start is %b on word %0d", o_start, word_idx));
        word_idx++;
        test_words++;
      end else begin
        assert (o_start !== 1'b1) else report_mismatch("start without valid");
      end
      if (o_finish) begin
        assert (!o_valid) else report_mismatch("finish together with valid");
        assert (word_idx == cur_len)
          else report_mismatch($sformatf("line of %0d words, expected %0d", word_idx, cur_len));
        word_idx = 0;
        test_lines++;
        total_lines++;
      end
    end
  end

  task automatic run_test(input int t);
    int          errors_before;
    int          lines_expected;
    logic [31:0] rdata;
    logic        err;
    errors_before = errors;
    cur_len       = row_len[t];
    test_words    = 0;
    test_lines    = 0;
    apb_write(`LB_REG_LEN, row_len[t]);
    apb_write(`LB_REG_CTRL, {31'd0, row_enable[t]});
    fork
      begin
        send_pixels(row_len[t] * row_lines[t]);
        if (row_hold[t]) begin
          assert (o_pix_ready === (row_lines[t] < 2))
            else report_mismatch($sformatf("pix_ready is %b with %0d lines held",
                                           o_pix_ready, row_lines[t]));
          assert (test_words == 0) else report_failure("output started while held back");
        end
      end
      begin
        repeat (row_ready[t]) @(negedge clk);
        i_out_ready = 1'b1;
      end
    join
    if (!row_enable[t]) begin
      apb_access(1'b0, `LB_REG_STATUS, '0, rdata, err);
      assert (rdata[2:0] == 3'd0 && rdata[5:4] == 2'(row_lines[t]))
        else report_mismatch($sformatf("STATUS 0x%h while disabled", rdata));
      apb_write(`LB_REG_CTRL, 32'd1);
    end
    wait (test_lines == row_lines[t]);
    repeat (2) @(negedge clk);
    assert (o_pix_ready === 1'b1) else report_mismatch("pix_ready low after drain");
    assert (expected_q.size() == 0) else report_failure("written pixels never came out");
    apb_access(1'b0, `LB_REG_STATUS, '0, rdata, err);
    assert (rdata[5:0] == 6'd0) else report_mismatch($sformatf("STATUS 0x%h at end", rdata));
    lines_expected = 0;
    for (int r = 0; r <= t; r++) lines_expected += row_lines[r];  // Lines written so far.
    apb_access(1'b0, `LB_REG_COUNT, '0, rdata, err);
    assert (rdata == 32'(lines_expected))
      else report_mismatch($sformatf("COUNT %0d expected %0d", rdata, lines_expected));
    i_out_ready = 1'b0;
    if (errors != errors_before) tests_failed++;
    $display("test %0d: len %0d, %0d lines, %0d words: %s", t + 1, row_len[t],
             row_lines[t], test_words, (errors == errors_before) ? "ok" : "fail");
  endtask

  initial begin
    logic [31:0] rdata;
    logic        err;
    int          errors_before;
    rst_n       = 1'b0;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_pix_valid = 1'b0;
    i_pix_data  = '0;
    i_out_ready = 1'b0;
    errors      = 0;
    word_idx    = 0;
    total_lines = 0;
    tests_failed = 0;
    void'($urandom(32'h87eb));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    for (int t = 0; t < NUM_TESTS; t++) run_test(t);

    // Error response on the register map.
    errors_before = errors;
    apb_access(1'b0, 4'h2, '0, rdata, err);
    assert (err === 1'b1) else report_mismatch("no pslverr on offset 0x2");
    apb_access(1'b1, 4'h6, 32'd1, rdata, err);
    assert (err === 1'b1) else report_mismatch("no pslverr on write to offset 0x6");
    apb_access(1'b0, `LB_REG_CTRL, '0, rdata, err);
    assert (err === 1'b0) else report_mismatch("pslverr on CTRL read");
    if (errors != errors_before) tests_failed++;
    $display("test %0d: APB error response: %s", NUM_TESTS + 1,
             (errors == errors_before) ? "ok" : "fail");

    $display("%0d tests run, %0d failed, %0d check errors, %0d lines out",
             NUM_TESTS + 1, tests_failed, errors, total_lines);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
hw/lb_pkg.sv
hw/lb_apb_regs.sv
hw/lb_write_port.sv
hw/lb_line_ram.sv
hw/lb_read_port.sv
hw/line_buffer_controller.sv
hw/line_buffer_top.sv
bench/tb_line_buffer.sv

// File: Bender.yml
package:
  name: line_buffer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/lb_pkg.sv
      - hw/lb_apb_regs.sv
      - hw/lb_write_port.sv
      - hw/lb_line_ram.sv
      - hw/lb_read_port.sv
      - hw/line_buffer_controller.sv
      - hw/line_buffer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_line_buffer.sv
